/* design/conv_pixels.sv */
`default_nettype none

`include "conv_router_defines.svh"

module conv_pixels
    import conv_router_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       advance,
    input  wire conv_cfg_t  cfg_q,
    output blk_step_t       blk
);

    localparam int CNT_W = `DIM_W - `PIXELS_IN_ROW_LOG2;

    logic [CNT_W-1:0]  blk_cnt;
    logic [CNT_W-1:0]  last_blk;
    logic [`DIM_W-1:0] ix;
    logic              first;
    logic              last;

    ////////////////////
    // block sweep
    ////////////////////

    assign ix       = `DIM_W'(1) << cfg_q.ix_log2;
    // blocks per row minus one
    assign last_blk = (CNT_W'(1) << (cfg_q.ix_log2 - `PIXELS_IN_ROW_LOG2)) - CNT_W'(1);

    assign first = (blk_cnt == '0);
    assign last  = (blk_cnt == last_blk);

    always_ff @(posedge clk) begin
        if (reset) begin
            blk_cnt <= '0;
        end else if (advance) begin
            if (last) begin
                blk_cnt <= '0;
            end else begin
                blk_cnt <= blk_cnt + CNT_W'(1);
            end
        end
    end

    assign blk.row_start_idx = {blk_cnt, {`PIXELS_IN_ROW_LOG2{1'b0}}};
    // pad columns only at the row edges
    assign blk.west_pad      = cfg_q.pad & first;
    assign blk.east_pad      = cfg_q.pad & last;
    assign blk.blk_last      = last;

    // whole block inside the input width
    blk_in_row: assert property (@(posedge clk) disable iff (reset)
        advance |-> (blk.row_start_idx + `DIM_W'(`PIXELS_IN_ROW) <= ix));

endmodule

`default_nettype wire

/* design/conv_router.sv */
`default_nettype none

`include "conv_router_defines.svh"

module conv_router
    import conv_router_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        start,
    input  wire conv_cfg_t   cfg,
    output logic             busy,
    output logic             done,
    output logic [`DIM_W-1:0] oy_start,
    output logic [1:0]       k_row,
    output blk_step_t        blk,
    output row_addr_t        row1,
    output row_addr_t        row2,
    output row_addr_t        row3
);

    conv_cfg_t  cfg_q;
    tile_step_t tile;

    ////////////////////
    // tile and block loops
    ////////////////////

    conv_tiling tiling0 (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .cfg      (cfg),
        .blk_last (blk.blk_last),
        .cfg_q    (cfg_q),
        .tile     (tile),
        .advance  (busy),
        .done     (done)
    );

    conv_pixels pixels0 (
        .clk      (clk),
        .reset    (reset),
        .advance  (busy),
        .cfg_q    (cfg_q),
        .blk      (blk)
    );

    assign oy_start = tile.oy_start;
    assign k_row    = tile.k_row;

    ////////////////////
    // row translators
    ////////////////////

    row_addr_translate #(.ROW_NUM(1)) row_tr1 (
        .cfg_q (cfg_q),
        .tile  (tile),
        .blk   (blk),
        .row   (row1)
    );

    row_addr_translate #(.ROW_NUM(2)) row_tr2 (
        .cfg_q (cfg_q),
        .tile  (tile),
        .blk   (blk),
        .row   (row2)
    );

    row_addr_translate #(.ROW_NUM(3)) row_tr3 (
        .cfg_q (cfg_q),
        .tile  (tile),
        .blk   (blk),
        .row   (row3)
    );

endmodule

`default_nettype wire

/* design/conv_router_defines.svh */
`ifndef CONV_ROUTER_DEFINES_SVH
`define CONV_ROUTER_DEFINES_SVH

////////////////////
// kernel and tiling
////////////////////

// square kernel, also the number of output rows per tile
`define KERNEL_SIZE 3

////////////////////
// line buffers
////////////////////

// pixels in one column block
`define PIXELS_IN_ROW 32
`define PIXELS_IN_ROW_LOG2 5

// line buffers, one input row each
`define BUFFERS_NUM 3

// dimensions and addresses
`define DIM_W 16

// marker for no row
`define ROW_INVALID {`DIM_W{1'b1}}

`endif

/* design/conv_router_pkg.sv */
`default_nettype none

`include "conv_router_defines.svh"

package conv_router_pkg;

    ////////////////////
    // enums
    ////////////////////

    // encoded as the stride value itself
    typedef enum logic [1:0] {
        STRIDE_1 = 2'd1,
        STRIDE_2 = 2'd2
    } stride_e;

    typedef enum logic [0:0] {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } state_e;

    ////////////////////
    // structs
    ////////////////////

    typedef struct packed {
        logic [3:0]            ix_log2;
        logic [`DIM_W-1:0]     iy;
        logic [`DIM_W-1:0]     oy;
        stride_e               stride;
        logic                  pad;
        logic [4:0]            reserved;
    } conv_cfg_t;

    // one kernel row step of a tile
    typedef struct packed {
        logic [`DIM_W-1:0]     oy_start;   // 1-based
        logic [1:0]            poy;
        logic [1:0]            k_row;
        logic [`DIM_W-1:0]     row_base;   // 3 * stride * tile number
        logic [`DIM_W-1:0]     slot_base;  // row_base / 3
        logic                  run;
    } tile_step_t;

    typedef struct packed {
        logic [`DIM_W-1:0]     row_start_idx;
        logic                  west_pad;
        logic                  east_pad;
        logic                  blk_last;
    } blk_step_t;

    typedef struct packed {
        logic                  valid;
        logic                  pad;
        logic [`DIM_W-1:0]     row_y;
        logic [1:0]            buf_idx;
        logic [`DIM_W-1:0]     buf_adr;
    } row_addr_t;

endpackage

`default_nettype wire

/* design/conv_tiling.sv */
`default_nettype none

`include "conv_router_defines.svh"

module conv_tiling
    import conv_router_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       start,
    input  wire conv_cfg_t  cfg,
    input  wire logic       blk_last,
    output conv_cfg_t       cfg_q,
    output tile_step_t      tile,
    output logic            advance,
    output logic            done
);

    localparam logic [1:0] K_ROW_LAST = 2'(`KERNEL_SIZE - 1);
    localparam logic [`DIM_W-1:0] TILE_ROWS = `DIM_W'(`KERNEL_SIZE);

    state_e state;

    logic [`DIM_W-1:0] oy_start;
    logic [1:0]        k_row;
    logic [`DIM_W-1:0] row_base;
    logic [`DIM_W-1:0] slot_base;

    logic [`DIM_W-1:0] stride_n;
    logic [`DIM_W-1:0] stride_x3;
    logic [`DIM_W-1:0] rows_left;
    logic              run;
    logic              last_krow;
    logic              last_tile;

    ////////////////////
    // step arithmetic
    ////////////////////

    assign stride_n  = {{(`DIM_W-2){1'b0}}, cfg_q.stride};
    // 3 * stride, shift and add
    assign stride_x3 = (stride_n << 1) + stride_n;

    assign rows_left = cfg_q.oy - oy_start + `DIM_W'(1);
    assign last_krow = (k_row == K_ROW_LAST);
    assign last_tile = (rows_left <= TILE_ROWS);
    assign run       = (state == ST_RUN);

    assign advance = run;
    // high together with the last step
    assign done    = run & blk_last & last_krow & last_tile;

    assign tile.oy_start  = oy_start;
    assign tile.poy       = last_tile ? rows_left[1:0] : TILE_ROWS[1:0];
    assign tile.k_row     = k_row;
    assign tile.row_base  = row_base;
    assign tile.slot_base = slot_base;
    assign tile.run       = run;

    ////////////////////
    // control
    ////////////////////

    // configuration is payload, latched on start only
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            cfg_q <= cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            oy_start  <= `DIM_W'(1);
            k_row     <= 2'd0;
            row_base  <= '0;
            slot_base <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_RUN;
                        oy_start  <= `DIM_W'(1);
                        k_row     <= 2'd0;
                        row_base  <= '0;
                        slot_base <= '0;
                    end
                end
                ST_RUN: begin
                    if (blk_last) begin
                        if (last_krow) begin
                            // next tile
                            k_row     <= 2'd0;
                            oy_start  <= oy_start + TILE_ROWS;
                            row_base  <= row_base + stride_x3;
                            slot_base <= slot_base + stride_n;
                            if (last_tile) begin
                                state <= ST_IDLE;
                            end
                        end else begin
                            k_row <= k_row + 2'd1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    k_row_range: assert property (@(posedge clk) disable iff (reset)
        k_row <= K_ROW_LAST);

endmodule

`default_nettype wire

/* design/row_addr_translate.sv */
`default_nettype none

`include "conv_router_defines.svh"

module row_addr_translate
    import conv_router_pkg::*;
#(
    parameter int ROW_NUM = 1
) (
    input  wire conv_cfg_t   cfg_q,
    input  wire tile_step_t  tile,
    input  wire blk_step_t   blk,
    output row_addr_t        row
);

    localparam logic [3:0] ROW_OFS = 4'(ROW_NUM - 1);
    localparam logic [3:0] BUF_N   = 4'(`BUFFERS_NUM);

    logic [3:0]        stride_n;
    logic [3:0]        stride_x3;
    logic [3:0]        row_step;
    logic [3:0]        bias0;
    logic [3:0]        bias;
    logic              wrap;
    logic [`DIM_W-1:0] base;
    logic [`DIM_W-1:0] slot_base;
    logic [`DIM_W-1:0] row_y;

    logic              leq3;
    logic              leq6;
    logic              leq9;
    logic [3:0]        idx_w;
    logic [1:0]        ofs;
    logic [`DIM_W-1:0] slot;
    logic [`DIM_W-1:0] adr;

    logic              valid;
    logic              pad_row;

    ////////////////////
    // base and bias
    ////////////////////

    assign stride_n  = {2'b00, cfg_q.stride};
    assign stride_x3 = (stride_n << 1) + stride_n;
    assign row_step  = (cfg_q.stride == STRIDE_2) ? (ROW_OFS << 1) : ROW_OFS;

    // offset of the input row above the tile base, may come out zero
    assign bias0 = {2'b00, tile.k_row} + 4'd1 + row_step - {3'b000, cfg_q.pad};

    // zero bias borrows one tile from the base
    assign wrap      = (bias0 == 4'd0);
    assign bias      = wrap ? bias0 + stride_x3 : bias0;
    assign base      = wrap ? tile.row_base - {{(`DIM_W-4){1'b0}}, stride_x3}
                            : tile.row_base;
    assign slot_base = wrap ? tile.slot_base - {{(`DIM_W-4){1'b0}}, stride_n}
                            : tile.slot_base;

    assign row_y = base + {{(`DIM_W-4){1'b0}}, bias};

    ////////////////////
    // buffer ladder
    ////////////////////

    assign leq3 = (bias <= BUF_N);
    assign leq6 = (bias <= (BUF_N << 1));
    assign leq9 = (bias <= (BUF_N << 1) + BUF_N);

    always_comb begin
        if (leq3) begin
            idx_w = bias - 4'd1;
            ofs   = 2'd0;
        end else if (leq6) begin
            idx_w = bias - 4'd1 - BUF_N;
            ofs   = 2'd1;
        end else if (leq9) begin
            idx_w = bias - 4'd1 - (BUF_N << 1);
            ofs   = 2'd2;
        end else begin
            idx_w = bias - 4'd1 - (BUF_N << 1) - BUF_N;
            ofs   = 2'd3;
        end
    end

    assign slot = slot_base + {{(`DIM_W-2){1'b0}}, ofs};
    // one channel, slots are a full input row apart
    assign adr  = (slot << cfg_q.ix_log2) + blk.row_start_idx;

    ////////////////////
    // row result
    ////////////////////

    assign valid   = tile.run & (ROW_NUM <= int'(tile.poy));
    assign pad_row = (row_y == '0) | (row_y > cfg_q.iy);

    always_comb begin
        row = '0;
        row.valid = valid;
        if (!valid) begin
            row.row_y = `ROW_INVALID;
        end else begin
            row.pad   = pad_row;
            row.row_y = row_y;
            if (!pad_row) begin
                row.buf_idx = idx_w[1:0];
                row.buf_adr = adr;
            end
        end
    end

    // slot from the tiling counters must agree with the row number
    slot_decomp: assert final (!(row.valid && !row.pad) ||
        ((slot << 1) + slot + {{(`DIM_W-2){1'b0}}, row.buf_idx} + `DIM_W'(1) == row.row_y));

endmodule

`default_nettype wire

/* tests/conv_router_model.svh */
`ifndef CONV_ROUTER_MODEL_SVH
`define CONV_ROUTER_MODEL_SVH

////////////////////
// loop nest sizes
////////////////////

function automatic int blocks_per_row(conv_cfg_t c);
    return 1 << (int'(c.ix_log2) - `PIXELS_IN_ROW_LOG2);
endfunction

function automatic int tile_count(conv_cfg_t c);
    return (int'(c.oy) + `KERNEL_SIZE - 1) / `KERNEL_SIZE;
endfunction

function automatic int step_count(conv_cfg_t c);
    return tile_count(c) * `KERNEL_SIZE * blocks_per_row(c);
endfunction

////////////////////
// position of step n
////////////////////

// first output row of the tile, 1-based
function automatic int tile_first_row(conv_cfg_t c, int n);
    return 1 + `KERNEL_SIZE * (n / (`KERNEL_SIZE * blocks_per_row(c)));
endfunction

function automatic int kernel_row_of(conv_cfg_t c, int n);
    return (n / blocks_per_row(c)) % `KERNEL_SIZE;
endfunction

// block is the innermost loop
function automatic blk_step_t predict_blk(conv_cfg_t c, int n);
    blk_step_t b;
    int nb;
    int blk_no;
    nb = blocks_per_row(c);
    blk_no = n % nb;
    b.row_start_idx = `DIM_W'(blk_no * `PIXELS_IN_ROW);
    b.west_pad = c.pad && (blk_no == 0);
    b.east_pad = c.pad && (blk_no == nb - 1);
    b.blk_last = (blk_no == nb - 1);
    return b;
endfunction

////////////////////
// row result
////////////////////

function automatic row_addr_t predict_row(conv_cfg_t c, int n, int r);
    row_addr_t e;
    int first;
    int poy;
    int y;
    int blk_no;
    first = tile_first_row(c, n);
    poy = int'(c.oy) - first + 1;
    if (poy > `KERNEL_SIZE) begin
        poy = `KERNEL_SIZE;
    end
    blk_no = n % blocks_per_row(c);
    e = '0;
    if (r > poy) begin
        e.row_y = `ROW_INVALID;
    end else begin
        // top input row of output row (first + r - 1), plus kernel row
        y = (first + r - 2) * int'(c.stride) + kernel_row_of(c, n) + 1 - int'(c.pad);
        e.valid = 1'b1;
        e.row_y = `DIM_W'(y);
        if (y < 1 || y > int'(c.iy)) begin
            e.pad = 1'b1;
        end else begin
            e.buf_idx = 2'((y - 1) % `BUFFERS_NUM);
            e.buf_adr = `DIM_W'(((y - 1) / `BUFFERS_NUM) * (1 << int'(c.ix_log2))
                                + blk_no * `PIXELS_IN_ROW);
        end
    end
    return e;
endfunction

`endif

/* tests/tb_conv_router.sv */
`default_nettype none

`include "conv_router_defines.svh"

module tb_conv_router
    import conv_router_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int NUM_RUNS = 40;

    logic              clk;
    logic              reset;
    logic              start;
    conv_cfg_t         cfg;
    logic              busy;
    logic              done;
    logic [`DIM_W-1:0] oy_start;
    logic [1:0]        k_row;
    blk_step_t         blk;
    row_addr_t         row1;
    row_addr_t         row2;
    row_addr_t         row3;

    integer    seed;
    int        errors;
    int        checks;
    int        run_no;
    int        step_no;
    bit        timed_out;
    conv_cfg_t run_cfg;

    `include "conv_router_model.svh"

    conv_router dut0 (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .cfg      (cfg),
        .busy     (busy),
        .done     (done),
        .oy_start (oy_start),
        .k_row    (k_row),
        .blk      (blk),
        .row1     (row1),
        .row2     (row2),
        .row3     (row3)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("mismatch at %0t: run %0d step %0d %s got 0x%0h expected 0x%0h",
                 $time, run_no, step_no, what, got, exp);
    endtask

    task automatic check_idle(string when);
        checks++;
        if (busy !== 1'b0) report_mismatch({when, " busy"}, busy, 0);
        if (done !== 1'b0) report_mismatch({when, " done"}, done, 0);
        if (row1.valid !== 1'b0) report_mismatch({when, " row1 valid"}, row1.valid, 0);
        if (row2.valid !== 1'b0) report_mismatch({when, " row2 valid"}, row2.valid, 0);
        if (row3.valid !== 1'b0) report_mismatch({when, " row3 valid"}, row3.valid, 0);
    endtask

    task automatic check_row(string name, row_addr_t got, row_addr_t exp);
        if (got.valid !== exp.valid) report_mismatch({name, " valid"}, got.valid, exp.valid);
        if (got.pad !== exp.pad) report_mismatch({name, " pad"}, got.pad, exp.pad);
        if (got.row_y !== exp.row_y) report_mismatch({name, " row_y"}, got.row_y, exp.row_y);
        if (got.buf_idx !== exp.buf_idx) begin
            report_mismatch({name, " buf_idx"}, got.buf_idx, exp.buf_idx);
        end
        if (got.buf_adr !== exp.buf_adr) begin
            report_mismatch({name, " buf_adr"}, got.buf_adr, exp.buf_adr);
        end
    endtask

    task automatic check_step(conv_cfg_t c, int n, int steps);
        blk_step_t eb;
        eb = predict_blk(c, n);
        checks++;
        if (busy !== 1'b1) report_mismatch("busy", busy, 1);
        if (done !== (n == steps - 1)) report_mismatch("done", done, n == steps - 1);
        if (oy_start !== `DIM_W'(tile_first_row(c, n))) begin
            report_mismatch("oy_start", oy_start, tile_first_row(c, n));
        end
        if (k_row !== 2'(kernel_row_of(c, n))) report_mismatch("k_row", k_row, kernel_row_of(c, n));
        if (blk.row_start_idx !== eb.row_start_idx) begin
            report_mismatch("row_start_idx", blk.row_start_idx, eb.row_start_idx);
        end
        if (blk.west_pad !== eb.west_pad) report_mismatch("west_pad", blk.west_pad, eb.west_pad);
        if (blk.east_pad !== eb.east_pad) report_mismatch("east_pad", blk.east_pad, eb.east_pad);
        if (blk.blk_last !== eb.blk_last) begin
            report_mismatch("blk_last", blk.blk_last, eb.blk_last);
        end
        check_row("row1", row1, predict_row(c, n, 1));
        check_row("row2", row2, predict_row(c, n, 2));
        check_row("row3", row3, predict_row(c, n, 3));
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic pick_config(output conv_cfg_t c);
        c = '0;
        c.ix_log2 = 4'(5 + $unsigned($random(seed)) % 3);
        c.iy = `DIM_W'(3 + $unsigned($random(seed)) % 38);
        c.stride = ($unsigned($random(seed)) % 2 == 0) ? STRIDE_1 : STRIDE_2;
        c.pad = 1'($unsigned($random(seed)) % 2);
        c.oy = `DIM_W'((int'(c.iy) + 2 * int'(c.pad) - 3) / int'(c.stride) + 1);
    endtask

    // late_start fires a second start halfway through the run
    task automatic run_config(conv_cfg_t c, bit late_start);
        int steps;
        int cycles;
        bit seen_done;
        conv_cfg_t junk;
        steps = step_count(c);
        @(posedge clk);
        #2;
        cfg = c;
        start = 1'b1;
        step_no = 0;
        cycles = 0;
        seen_done = 1'b0;
        while (!seen_done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
            check_step(c, step_no, steps);
            seen_done = (done === 1'b1);
            #1;
            start = 1'b0;
            if (late_start && step_no == (steps - 1) / 2) begin
                pick_config(junk);
                cfg = junk;
                start = 1'b1;
            end
            step_no++;
        end
        start = 1'b0;
        if (!seen_done) begin
            $display("timeout: run %0d gave no done within %0d cycles", run_no, TIMEOUT_CYCLES);
            errors++;
            timed_out = 1'b1;
        end else begin
            if (step_no != steps) report_mismatch("step count", step_no, steps);
            // an accepted second start would restart the sweep here
            repeat (3) begin
                @(posedge clk);
                #1;
                check_idle("after done");
            end
        end
    endtask

    initial begin
        seed = 36;
        errors = 0;
        checks = 0;
        run_no = 0;
        step_no = 0;
        timed_out = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        cfg = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_idle("after reset");

        for (run_no = 0; run_no < NUM_RUNS && !timed_out; run_no++) begin
            pick_config(run_cfg);
            run_config(run_cfg, run_no % 2 == 1);
        end

        $display("runs %0d checks %0d errors %0d", run_no, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
+incdir+tests
design/conv_router_pkg.sv
design/conv_tiling.sv
design/conv_pixels.sv
design/row_addr_translate.sv
design/conv_router.sv
tests/tb_conv_router.sv
